// ==== vlog.f ====
hdl/riscv_pkg.sv
hdl/control_fsm.sv
hdl/instr_decode.sv
hdl/alu.sv
hdl/register_file.sv
hdl/pc_unit.sv
hdl/load_store_unit.sv
hdl/riscv_core.sv
test/riscv_core_properties.sv
test/tb_riscv_core.sv

// ==== Makefile ====
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_riscv_core -Mdir obj_dir

run: build
	./obj_dir/Vtb_riscv_core > sim.log 2>&1; cat sim.log
	@if grep -q "STATUS: FAIL" sim.log || ! grep -q "STATUS: PASS" sim.log; then exit 1; fi

lint:
	verilator --lint-only --timing -f vlog.f --top-module tb_riscv_core

clean:
	rm -rf obj_dir sim.log

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/10ps

module tb_riscv_core import riscv_pkg::*; ();

  logic     clk;
  logic     rst_n;
  addr_t    mem_address;
  data_t    mem_write_data;
  byte_en_t mem_write_enable;
  data_t    mem_read_data = '0;
  data_t    dbg_regs [reg_count];
  addr_t    dbg_pc;
  logic     retire;

  data_t  mem [256];  // 1 KiB seen by the dut.
  data_t  model_mem [256];
  data_t  model_regs [reg_count];
  addr_t  model_pc;
  integer seed;
  int     n_pass;
  int     n_err;
  int     prog_len = 200;
  int     reset_cycles = 10;
  int     data_base = 832;  // data region above the program.

  riscv_core i_riscv_core (
    .clk              (clk),
    .rst_n            (rst_n),
    .mem_address      (mem_address),
    .mem_write_data   (mem_write_data),
    .mem_write_enable (mem_write_enable),
    .mem_read_data    (mem_read_data),
    .dbg_regs         (dbg_regs),
    .dbg_pc           (dbg_pc),
    .retire           (retire)
  );

  always #50 clk = ~clk;

  // memory model, written lane by lane, read data driven on the falling edge.
  always @(negedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (mem_write_enable[i]) begin
        mem[mem_address[9:2]][i*8 +: 8] = mem_write_data[i*8 +: 8];
      end
    end
    mem_read_data = mem[mem_address[9:2]];
  end

  task automatic check_pc(input string name, input addr_t exp, input addr_t act);
    if (exp === act) begin
      n_pass++;
    end else begin
      n_err++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input data_t exp, input data_t act);
    if (exp === act) begin
      n_pass++;
    end else begin
      n_err++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_mem(input string name, input data_t exp, input data_t act);
    if (exp === act) begin
      n_pass++;
    end else begin
      n_err++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  function automatic int rnd(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                   input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                   input logic [2:0] f3);
    return {imm[11:5], rs2, 5'd0, f3, imm[4:0], 7'h23};
  endfunction

  function automatic instr_t enc_b(input logic [12:0] imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                   input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic instr_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  task automatic put(input int slot, input instr_t ins);
    mem[slot] = ins;
    model_mem[slot] = ins;
  endtask

  // random program with forward control flow only, closed by a jal to itself.
  task automatic gen_program();
    int i;
    int kind;
    int f3;
    int imm;
    int size;
    int t;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rx;
    logic targeted [256];  // slots reached by a forward jump.
    for (int s = 0; s < 256; s++) begin
      targeted[s] = 1'b0;
    end
    i = 0;
    while (i < prog_len - 1) begin
      kind = rnd(9);
      rd = reg_idx_t'(rnd(32));
      rs1 = reg_idx_t'(rnd(32));
      rs2 = reg_idx_t'(rnd(32));
      if (kind == 8 && (i + 3 > prog_len - 1 || targeted[i + 1] || targeted[i + 2])) begin
        kind = 0;
      end
      case (kind)
        0: begin
          f3 = rnd(8);
          put(i, enc_r(((f3 == 0 || f3 == 5) && rnd(2) == 1) ? 7'h20 : 7'h00,
                       rs2, rs1, 3'(f3), rd));
        end
        1: begin
          f3 = rnd(8);
          if (f3 == 1) imm = rnd(32);
          else if (f3 == 5) imm = rnd(32) + rnd(2) * 1024;  // bit 30 picks srai.
          else imm = rnd(4096);
          put(i, enc_i(12'(imm), rs1, 3'(f3), rd, 7'h13));
        end
        2, 3: put(i, {20'(rnd(1 << 20)), rd, (kind == 2) ? 7'h37 : 7'h17});
        4: begin
          case (rnd(5))
            0: f3 = 0;
            1: f3 = 1;
            2: f3 = 2;
            3: f3 = 4;
            default: f3 = 5;
          endcase
          size = 1 << (f3 % 4);
          imm = data_base + (rnd(192) & ~(size - 1));
          put(i, enc_i(12'(imm), 5'd0, 3'(f3), rd, 7'h03));
        end
        5: begin
          f3 = rnd(3);
          size = 1 << f3;
          imm = data_base + (rnd(192) & ~(size - 1));
          put(i, enc_s(12'(imm), rs2, 3'(f3)));
        end
        6: begin
          case (rnd(6))
            0: f3 = 0;
            1: f3 = 1;
            2: f3 = 4;
            3: f3 = 5;
            4: f3 = 6;
            default: f3 = 7;
          endcase
          t = i + 1 + rnd(prog_len - 1 - i);
          targeted[t] = 1'b1;
          put(i, enc_b(13'((t - i) * 4), rs2, rs1, 3'(f3)));
        end
        7: begin
          t = i + 1 + rnd(prog_len - 1 - i);
          targeted[t] = 1'b1;
          put(i, enc_j(21'((t - i) * 4), rd));
        end
        default: begin
          rx = reg_idx_t'(1 + rnd(31));
          t = i + 3 + rnd(prog_len - 3 - i);
          targeted[t] = 1'b1;
          put(i, {20'd0, rx, 7'h37});
          put(i + 1, enc_i(12'(t * 4), rx, 3'd0, rx, 7'h13));
          put(i + 2, enc_i(12'd0, rx, 3'd0, rd, 7'h67));
          i += 2;
        end
      endcase
      i++;
    end
    put(prog_len - 1, enc_j(21'd0, 5'd0));
  endtask

  function automatic data_t alu_ref(input logic [2:0] f3, input logic alt,
                                    input data_t x, input data_t y);
    data_t r;
    case (f3)
      3'd0: r = alt ? x - y : x + y;
      3'd1: r = x << y[4:0];
      3'd2: r = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      3'd3: r = (x < y) ? 32'd1 : 32'd0;
      3'd4: r = x ^ y;
      3'd5: begin
        if (alt) r = $signed(x) >>> y[4:0];
        else r = x >> y[4:0];
      end
      3'd6: r = x | y;
      default: r = x & y;
    endcase
    return r;
  endfunction

  // executes one instruction on the model state.
  task automatic run_model(input instr_t ins, output int cycles, output logic wr_reg,
                           output reg_idx_t rd, output logic wr_mem, output int word);
    data_t a;
    data_t b;
    data_t imm_i;
    data_t imm_s;
    data_t imm_b;
    data_t imm_j;
    data_t adr;
    data_t val;
    data_t w;
    addr_t next_pc;
    logic [2:0] f3;
    logic [7:0] lb;
    logic [15:0] lh;
    logic taken;
    f3 = ins[14:12];
    rd = ins[11:7];
    a = model_regs[ins[19:15]];
    b = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next_pc = model_pc + 4;
    cycles = 4;
    wr_reg = 1'b1;
    wr_mem = 1'b0;
    word = 0;
    val = '0;
    case (ins[6:0])
      7'h33: val = alu_ref(f3, ins[30], a, b);
      7'h13: val = alu_ref(f3, ins[30] && f3 == 3'd5, a, imm_i);
      7'h37: val = {ins[31:12], 12'd0};
      7'h17: val = model_pc + {ins[31:12], 12'd0};
      7'h03: begin
        cycles = 5;
        adr = a + imm_i;
        w = model_mem[adr[9:2]];
        lb = w[{adr[1:0], 3'b000} +: 8];
        lh = w[{adr[1], 4'b0000} +: 16];
        case (f3)
          3'd0: val = {{24{lb[7]}}, lb};
          3'd1: val = {{16{lh[15]}}, lh};
          3'd4: val = {24'd0, lb};
          3'd5: val = {16'd0, lh};
          default: val = w;
        endcase
      end
      7'h23: begin
        wr_reg = 1'b0;
        wr_mem = 1'b1;
        adr = a + imm_s;
        word = int'(adr[9:2]);
        w = model_mem[word];
        case (f3)
          3'd0: w[{adr[1:0], 3'b000} +: 8] = b[7:0];
          3'd1: w[{adr[1], 4'b0000} +: 16] = b[15:0];
          default: w = b;
        endcase
        model_mem[word] = w;
      end
      7'h63: begin
        cycles = 3;
        wr_reg = 1'b0;
        case (f3)
          3'd0: taken = (a == b);
          3'd1: taken = (a != b);
          3'd4: taken = $signed(a) < $signed(b);
          3'd5: taken = $signed(a) >= $signed(b);
          3'd6: taken = a < b;
          default: taken = a >= b;
        endcase
        if (taken) next_pc = model_pc + imm_b;
      end
      7'h6f: begin
        val = model_pc + 4;
        next_pc = model_pc + imm_j;
      end
      default: begin  // jalr.
        val = model_pc + 4;
        next_pc = (a + imm_i) & ~32'd1;
      end
    endcase
    if (wr_reg && rd != 5'd0) model_regs[rd] = val;
    model_pc = next_pc;
  endtask

  initial begin
    int cycles;
    int last_retire;
    int exp_cycles;
    int n_ret;
    int word;
    int test_pass;
    int test_err;
    int timeout_cycles;
    logic wr_reg;
    logic wr_mem;
    logic pending;
    logic final_instr;
    logic done;
    logic timed_out;
    reg_idx_t rd;
    instr_t ins;
    clk = 1'b0;
    rst_n = 1'b0;
    seed = 76;
    n_pass = 0;
    n_err = 0;
    timeout_cycles = prog_len * 5 + reset_cycles + 100;
    for (int w = 0; w < 256; w++) begin
      mem[w] = data_t'(w) * 32'h01010101 ^ 32'h5a3c0000;
      model_mem[w] = mem[w];
    end
    for (int r = 0; r < reg_count; r++) begin
      model_regs[r] = '0;
    end
    gen_program();
    model_pc = reset_pc;
    repeat (reset_cycles) @(negedge clk);
    rst_n = 1'b1;
    check_pc("reset pc", reset_pc, dbg_pc);
    for (int r = 0; r < reg_count; r++) begin
      check_reg($sformatf("reset x%0d", r), '0, dbg_regs[r]);
    end
    $display("test reset: %0d checks, %0d errors", n_pass + n_err, n_err);
    test_pass = n_pass;
    test_err = n_err;
    cycles = 0;
    last_retire = -1;  // fetch is already active at the release edge.
    n_ret = 0;
    pending = 1'b0;
    final_instr = 1'b0;
    done = 1'b0;
    timed_out = 1'b0;
    while (!done && !timed_out) begin
      @(negedge clk);
      cycles++;
      if (cycles > timeout_cycles) begin
        timed_out = 1'b1;
      end else if (retire) begin
        ins = model_mem[model_pc[9:2]];
        final_instr = (ins == enc_j(21'd0, 5'd0));
        check_pc($sformatf("pc of instruction %0d", n_ret), model_pc, dbg_pc);
        run_model(ins, exp_cycles, wr_reg, rd, wr_mem, word);
        if (cycles - last_retire != exp_cycles) begin
          n_err++;
          $display("Error cycles of instruction %0d (%h): expected %0d, actual %0d",
                   n_ret, ins, exp_cycles, cycles - last_retire);
        end
        last_retire = cycles;
        n_ret++;
        pending = 1'b1;
      end else if (pending) begin
        if (wr_reg) check_reg($sformatf("x%0d after instruction %0d", rd, n_ret - 1),
                              model_regs[rd], dbg_regs[rd]);
        if (wr_mem) check_mem($sformatf("word %0d after instruction %0d", word, n_ret - 1),
                              model_mem[word], mem[word]);
        pending = 1'b0;
        done = final_instr;
      end
    end
    if (timed_out) begin
      n_err++;
      $display("run stopped by timeout after %0d cycles with %0d instructions retired",
               timeout_cycles, n_ret);
    end
    $display("test program: %0d instructions, %0d checks, %0d errors", n_ret,
             n_pass + n_err - test_pass - test_err, n_err - test_err);
    $display("checks passed: %0d, errors: %0d", n_pass, n_err);
    if (n_err == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== test/riscv_core_properties.sv ====
`timescale 1ns/10ps

module riscv_core_properties import riscv_pkg::*; (
  input logic     clk,
  input logic     rst_n,
  input state_t   state,
  input byte_en_t mem_write_enable,
  input logic     retire
);

  a_write_only_in_mem_write: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_write_enable != '0) |-> (state == st_mem_write))
    else $error("memory write enable set outside the mem_write state");

  a_retire_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    retire |=> !retire)
    else $error("retire held high for more than one cycle");

  a_fetch_after_retire: assert property (@(posedge clk) disable iff (!rst_n)
    retire |=> (state == st_fetch))
    else $error("state after a retire is not fetch");

  a_fetch_after_reset: assert property (@(posedge clk) !rst_n |=> (state == st_fetch))
    else $error("state after reset is not fetch");

endmodule

bind control_fsm riscv_core_properties i_riscv_core_properties (
  .clk              (clk),
  .rst_n            (rst_n),
  .state            (state),
  .mem_write_enable (mem_write_enable),
  .retire           (retire)
);

// ==== hdl/riscv_core.sv ====
`timescale 1ns/10ps

module riscv_core import riscv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  output addr_t    mem_address,
  output data_t    mem_write_data,
  output byte_en_t mem_write_enable,
  input  data_t    mem_read_data,
  output data_t    dbg_regs [reg_count],
  output addr_t    dbg_pc,
  output logic     retire
);

  ctrl_t    ctrl;
  decode_t  dec;
  instr_t   ir;
  data_t    data_reg;
  data_t    a_reg;
  data_t    b_reg;
  data_t    alu_out;
  data_t    rd1;
  data_t    rd2;
  data_t    src_a;
  data_t    src_b;
  data_t    alu_result;
  data_t    result;
  data_t    load_data;
  alu_op_t  alu_op;
  logic     alu_zero;
  logic     branch_taken;
  byte_en_t byte_en;
  addr_t    pc;
  addr_t    pc_old;

  control_fsm i_control_fsm (
    .clk              (clk),
    .rst_n            (rst_n),
    .dec              (dec),
    .alu_zero         (alu_zero),
    .branch_taken     (branch_taken),
    .byte_en          (byte_en),
    .ctrl             (ctrl),
    .mem_write_enable (mem_write_enable),
    .retire           (retire),
    .state            ()
  );

  instr_decode i_instr_decode (
    .instr (ir),
    .dec   (dec)
  );

  register_file i_register_file (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1        (dec.rs1),
    .rs2        (dec.rs2),
    .rd         (dec.rd),
    .write_en   (ctrl.reg_write),
    .write_data (result),
    .rd1        (rd1),
    .rd2        (rd2),
    .dbg_regs   (dbg_regs)
  );

  pc_unit i_pc_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .pc_update (ctrl.pc_update),
    .ir_write  (ctrl.ir_write),
    .pc_src    (ctrl.pc_src),
    .result    (result),
    .alu_out   (alu_out),
    .pc        (pc),
    .pc_old    (pc_old)
  );

  assign alu_op = ctrl.alu_use_add ? alu_add : dec.alu_op;

  alu i_alu (
    .a            (src_a),
    .b            (src_b),
    .op           (alu_op),
    .funct3       (dec.funct3),
    .result       (alu_result),
    .zero         (alu_zero),
    .branch_taken (branch_taken)
  );

  load_store_unit i_load_store_unit (
    .funct3     (dec.funct3),
    .address    (mem_address),
    .store_data (b_reg),
    .read_data  (mem_read_data),
    .byte_en    (byte_en),
    .write_data (mem_write_data),
    .load_data  (load_data)
  );

  always_ff @(posedge clk) begin
    if (ctrl.ir_write) begin
      ir <= mem_read_data;
    end
    data_reg <= load_data;  // extended in the mem_read cycle.
    a_reg    <= rd1;
    b_reg    <= rd2;
    alu_out  <= alu_result;
  end

  always_comb begin
    case (ctrl.alu_src_a)
      src_a_pc:     src_a = pc;
      src_a_old_pc: src_a = pc_old;
      src_a_rs1:    src_a = a_reg;
      default:      src_a = '0;
    endcase
  end

  always_comb begin
    case (ctrl.alu_src_b)
      src_b_rs2:  src_b = b_reg;
      src_b_imm:  src_b = dec.imm;
      default:    src_b = data_t'(4);
    endcase
  end

  always_comb begin
    case (ctrl.result_src)
      res_mem_data:   result = data_reg;
      res_alu_result: result = alu_result;
      default:        result = alu_out;
    endcase
  end

  assign mem_address = (ctrl.adr_src == adr_result) ? result : pc;
  assign dbg_pc      = pc_old;  // pc of the retiring instruction.

endmodule

// ==== hdl/load_store_unit.sv ====
`timescale 1ns/10ps

module load_store_unit import riscv_pkg::*; (
  input  logic [2:0] funct3,
  input  addr_t      address,
  input  data_t      store_data,
  input  data_t      read_data,
  output byte_en_t   byte_en,
  output data_t      write_data,
  output data_t      load_data
);

  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  always_comb begin
    case (funct3[1:0])
      2'b00: begin
        byte_en    = byte_en_t'(4'b0001 << address[1:0]);
        write_data = {4{store_data[7:0]}};
      end
      2'b01: begin
        byte_en    = byte_en_t'(4'b0011 << {address[1], 1'b0});
        write_data = {2{store_data[15:0]}};
      end
      default: begin
        byte_en    = 4'b1111;
        write_data = store_data;
      end
    endcase
  end

  assign lane_byte = read_data[{address[1:0], 3'b000} +: 8];
  assign lane_half = read_data[{address[1], 4'b0000} +: 16];

  // funct3[2] selects zero extension.
  always_comb begin
    case (funct3)
      3'b000:  load_data = {{24{lane_byte[7]}}, lane_byte};
      3'b001:  load_data = {{16{lane_half[15]}}, lane_half};
      3'b100:  load_data = {24'b0, lane_byte};
      3'b101:  load_data = {16'b0, lane_half};
      default: load_data = read_data;
    endcase
  end

endmodule

// ==== hdl/pc_unit.sv ====
`timescale 1ns/10ps

module pc_unit import riscv_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    pc_update,
  input  logic    ir_write,
  input  pc_src_t pc_src,
  input  data_t   result,
  input  data_t   alu_out,
  output addr_t   pc,
  output addr_t   pc_old
);

  addr_t next_pc;

  // bit 0 cleared for jalr targets.
  always_comb begin
    next_pc = (pc_src == pc_src_alu_out) ? alu_out : result;
    next_pc[0] = 1'b0;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc     <= reset_pc;
      pc_old <= reset_pc;
    end else begin
      if (pc_update) begin
        pc <= next_pc;
      end
      if (ir_write) begin
        pc_old <= pc;  // pc of the instruction being fetched.
      end
    end
  end

endmodule

// ==== hdl/register_file.sv ====
`timescale 1ns/10ps

module register_file import riscv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  reg_idx_t rd,
  input  logic     write_en,
  input  data_t    write_data,
  output data_t    rd1,
  output data_t    rd2,
  output data_t    dbg_regs [reg_count]
);

  data_t regs [1:reg_count-1];  // x0 has no storage.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en && (rd != '0)) begin
      regs[rd] <= write_data;
    end
  end

  assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

  always_comb begin
    dbg_regs[0] = '0;
    for (int i = 1; i < reg_count; i++) begin
      dbg_regs[i] = regs[i];
    end
  end

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu import riscv_pkg::*; (
  input  data_t      a,
  input  data_t      b,
  input  alu_op_t    op,
  input  logic [2:0] funct3,
  output data_t      result,
  output logic       zero,
  output logic       branch_taken
);

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_and:    result = a & b;
      alu_or:     result = a | b;
      alu_xor:    result = a ^ b;
      alu_slt:    result = data_t'($signed(a) < $signed(b));
      alu_sltu:   result = data_t'(a < b);
      alu_sll:    result = a << b[4:0];
      alu_srl:    result = a >> b[4:0];
      alu_sra:    result = data_t'($signed(a) >>> b[4:0]);
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);

  always_comb begin
    case (funct3)
      3'b000:  branch_taken = (a == b);
      3'b001:  branch_taken = (a != b);
      3'b100:  branch_taken = $signed(a) < $signed(b);
      3'b101:  branch_taken = $signed(a) >= $signed(b);
      3'b110:  branch_taken = a < b;
      3'b111:  branch_taken = a >= b;
      default: branch_taken = 1'b0;
    endcase
  end

endmodule

// ==== hdl/instr_decode.sv ====
`timescale 1ns/10ps

module instr_decode import riscv_pkg::*; (
  input  instr_t  instr,
  output decode_t dec
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_5;
  data_t      imm_i;
  data_t      imm_s;
  data_t      imm_b;
  data_t      imm_u;
  data_t      imm_j;
  data_t      imm;
  alu_op_t    alu_op;

  assign opcode   = opcode_t'(instr[6:0]);
  assign funct3   = instr[14:12];
  assign funct7_5 = instr[30];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    case (opcode)
      opc_store:          imm = imm_s;
      opc_branch:         imm = imm_b;
      opc_lui, opc_auipc: imm = imm_u;
      opc_jal:            imm = imm_j;
      default:            imm = imm_i;
    endcase
  end

  always_comb begin
    alu_op = alu_add;  // loads, stores, jumps and auipc.
    case (opcode)
      opc_op, opc_op_imm: begin
        case (funct3)
          3'b000:  alu_op = (opcode == opc_op && funct7_5) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = funct7_5 ? alu_sra : alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      opc_branch: alu_op = alu_sub;
      opc_lui:    alu_op = alu_pass_b;
      default:    alu_op = alu_add;
    endcase
  end

  assign dec = '{opcode: opcode, funct3: funct3, funct7_5: funct7_5, rd: instr[11:7],
                 rs1: instr[19:15], rs2: instr[24:20], imm: imm, alu_op: alu_op};

endmodule

// ==== hdl/control_fsm.sv ====
`timescale 1ns/10ps

module control_fsm import riscv_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  decode_t  dec,
  input  logic     alu_zero,
  input  logic     branch_taken,
  input  byte_en_t byte_en,
  output ctrl_t    ctrl,
  output byte_en_t mem_write_enable,
  output logic     retire,
  output state_t   state
);

  state_t next_state;
  logic   taken;
  logic   is_jump;

  assign is_jump = (dec.opcode == opc_jal) || (dec.opcode == opc_jalr);

  // beq and bne come from the zero flag of the subtraction.
  assign taken = (dec.funct3[2:1] == 2'b00) ? (alu_zero ^ dec.funct3[0]) : branch_taken;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_fetch;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = st_fetch;
    case (state)
      st_fetch: next_state = st_decode;
      st_decode: begin
        case (dec.opcode)
          opc_load, opc_store: next_state = st_mem_adr;
          opc_op:              next_state = st_exec_r;
          opc_op_imm:          next_state = st_exec_i;
          opc_branch:          next_state = st_branch;
          opc_jal:             next_state = st_jal;
          opc_jalr:            next_state = st_jalr;
          opc_lui, opc_auipc:  next_state = st_lui;
          default:             next_state = st_fetch;  // unsupported, refetch.
        endcase
      end
      st_mem_adr:  next_state = (dec.opcode == opc_load) ? st_mem_read : st_mem_write;
      st_mem_read: next_state = st_mem_wb;
      st_exec_r, st_exec_i, st_lui, st_jal, st_jalr: next_state = st_alu_wb;
      default:     next_state = st_fetch;
    endcase
  end

  always_comb begin
    ctrl.adr_src     = adr_pc;
    ctrl.alu_src_a   = src_a_rs1;
    ctrl.alu_src_b   = src_b_rs2;
    ctrl.result_src  = res_alu_out;
    ctrl.pc_src      = pc_src_result;
    ctrl.ir_write    = 1'b0;
    ctrl.pc_update   = 1'b0;
    ctrl.reg_write   = 1'b0;
    ctrl.mem_write   = 1'b0;
    ctrl.alu_use_add = 1'b0;
    case (state)
      st_fetch: begin
        ctrl.ir_write    = 1'b1;
        ctrl.alu_src_a   = src_a_pc;
        ctrl.alu_src_b   = src_b_four;
        ctrl.alu_use_add = 1'b1;
        ctrl.result_src  = res_alu_result;
        ctrl.pc_update   = 1'b1;  // pc + 4.
      end
      st_decode: begin
        ctrl.alu_src_a   = src_a_old_pc;  // branch and jal target.
        ctrl.alu_src_b   = src_b_imm;
        ctrl.alu_use_add = 1'b1;
      end
      st_mem_adr: begin
        ctrl.alu_src_b   = src_b_imm;
        ctrl.alu_use_add = 1'b1;
      end
      st_mem_read: ctrl.adr_src = adr_result;
      st_mem_wb: begin
        ctrl.result_src = res_mem_data;
        ctrl.reg_write  = 1'b1;
      end
      st_mem_write: begin
        ctrl.adr_src   = adr_result;
        ctrl.mem_write = 1'b1;
      end
      st_exec_i: ctrl.alu_src_b = src_b_imm;
      st_lui: begin
        ctrl.alu_src_a = (dec.opcode == opc_auipc) ? src_a_old_pc : src_a_zero;
        ctrl.alu_src_b = src_b_imm;
      end
      st_alu_wb: begin
        ctrl.reg_write = 1'b1;
        if (is_jump) begin
          // link address is rebuilt from the instruction pc.
          ctrl.alu_src_a   = src_a_old_pc;
          ctrl.alu_src_b   = src_b_four;
          ctrl.alu_use_add = 1'b1;
          ctrl.result_src  = res_alu_result;
        end
      end
      st_branch: begin
        ctrl.pc_src    = pc_src_alu_out;
        ctrl.pc_update = taken;
      end
      st_jal: begin
        ctrl.pc_src    = pc_src_alu_out;
        ctrl.pc_update = 1'b1;
      end
      st_jalr: begin
        ctrl.alu_src_b   = src_b_imm;
        ctrl.alu_use_add = 1'b1;
        ctrl.result_src  = res_alu_result;
        ctrl.pc_update   = 1'b1;
      end
      default: ;
    endcase
  end

  assign mem_write_enable = ctrl.mem_write ? byte_en : '0;

  assign retire = (state == st_mem_wb) || (state == st_mem_write) ||
                  (state == st_alu_wb) || (state == st_branch);

endmodule

// ==== hdl/riscv_pkg.sv ====
package riscv_pkg;

  localparam int unsigned xlen = 32;
  localparam int unsigned reg_count = 32;

  typedef logic [xlen-1:0] addr_t;
  typedef logic [xlen-1:0] data_t;
  typedef logic [31:0]     instr_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [3:0]      byte_en_t;

  localparam addr_t reset_pc = '0;

  // major opcodes of the kept subset.
  typedef enum logic [6:0] {
    opc_op     = 7'b0110011,
    opc_op_imm = 7'b0010011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111
  } opcode_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
    alu_sltu, alu_sll, alu_srl, alu_sra, alu_pass_b
  } alu_op_t;

  typedef enum logic {adr_pc, adr_result} adr_src_t;
  typedef enum logic [1:0] {src_a_pc, src_a_old_pc, src_a_rs1, src_a_zero} alu_src_a_t;
  typedef enum logic [1:0] {src_b_rs2, src_b_imm, src_b_four} alu_src_b_t;
  typedef enum logic [1:0] {res_alu_out, res_mem_data, res_alu_result} result_src_t;
  typedef enum logic {pc_src_result, pc_src_alu_out} pc_src_t;

  typedef enum logic [3:0] {
    st_fetch, st_decode, st_mem_adr, st_mem_read, st_mem_wb, st_mem_write, st_exec_r,
    st_exec_i, st_alu_wb, st_branch, st_jal, st_jalr, st_lui
  } state_t;

  typedef struct packed {
    adr_src_t    adr_src;
    alu_src_a_t  alu_src_a;
    alu_src_b_t  alu_src_b;
    result_src_t result_src;
    pc_src_t     pc_src;
    logic        ir_write;
    logic        pc_update;
    logic        reg_write;
    logic        mem_write;
    logic        alu_use_add;  // override decoded op with add.
  } ctrl_t;

  typedef struct packed {
    opcode_t  opcode;
    logic [2:0] funct3;
    logic     funct7_5;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    data_t    imm;
    alu_op_t  alu_op;
  } decode_t;

endpackage
